// File: tb/video_input.txt
# op addr-or-count data, all hex
# W write, R read and expect data, X check count pixels, P expect next pixel colour
W 17 88
W 13 44
W 15 66
W 11 22
W 40 f0
W 48 cc
W 50 aa
W 5f ff
W 23 99
R 23 00
R 17 88
R 48 cc
R 5f ff
W 00 01
R 00 01
P 88
P 44
P 66
P 22
X 3c
P 88
W 00 00
R 00 00
R 65 00
R 30 00
W 00 01
P 88
X 10
W 00 00

// File: files.f
source/video_pkg.sv
source/video_ifs.sv
source/clock_enables.sv
source/wb_regs.sv
source/pixel_shifter.sv
source/palette_out.sv
source/video_top.sv
tb/video_assert.sv
tb/video_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = video_tb
FILELIST  = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/video_tb.sv
`timescale 1ns/10ps

module video_tb;

    localparam int ACK_TIMEOUT = 16;                     // Cycles for one bus access
    localparam int PIX_TIMEOUT = 64;                     // Cycles for the next pixel
    // 4.43361875 MHz / 24 MHz * 2^32 rounded to nearest
    localparam logic [31:0] SUB_DELTA = 32'(longint'(4.43361875e6 / 24.0e6 * 4294967296.0));

    logic       clk24;
    logic       rst_n;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [6:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic [7:0] pixel_color;
    logic       pixel_valid;
    logic       subcarrier;

    logic [31:0] lfsr;
    logic [7:0]  pal_m [16];                             // Palette copy
    logic [7:0]  plane_m [4][8];                         // Line buffer copy
    logic [7:0]  pix_q [$];                              // Colours seen while enabled
    int          rd_ptr = 0;
    int          pix_num = 0;                            // Pixel number from line start
    bit          tb_enable = 1'b0;
    bit          aborted = 1'b0;
    int          bus_errs = 0;
    int          data_errs = 0;
    int          timing_errs = 0;

    video_top video_top_i (.*);

    bind video_top video_assert video_assert_i (
        .clk24       (clk24),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_ack      (wb_ack),
        .ce12        (ce_bus.ce12),
        .ce6         (ce_bus.ce6),
        .ce6x        (ce_bus.ce6x),
        .ce3         (ce_bus.ce3),
        .ce1m5       (ce_bus.ce1m5),
        .video_slice (ce_bus.video_slice),
        .pipe_ab     (ce_bus.pipe_ab)
    );

    initial begin
        clk24 = 1'b0;
        forever #20 clk24 = ~clk24;                      // 25 MHz stand-in for 24 MHz
    end

    // Right shift Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Colour of pixel n of the line
    function automatic logic [7:0] model_color(input int n);
        int         col;
        int         bitn;
        logic [3:0] idx;
        col  = (n / 8) % 8;
        bitn = 7 - (n % 8);                              // MSB leaves first
        for (int p = 0; p < 4; p++) idx[p] = plane_m[p][col][bitn]; // Plane 3 is the index MSB
        return pal_m[idx];
    endfunction

    // ------------------------------
    // Wishbone master
    // ------------------------------
    task automatic bus_access(input logic we, input logic [6:0] adr, input logic [7:0] wdat,
                              output logic [7:0] rdat);
        int t;
        t    = 0;
        rdat = 8'h00;
        if (aborted) return;
        @(posedge clk24);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        @(negedge clk24);
        while (!wb_ack && t < ACK_TIMEOUT) begin
            t++;
            @(negedge clk24);
        end
        if (!wb_ack) begin
            $display("The Wishbone slave never acknowledged the access to address %h", adr);
            aborted = 1'b1;
        end
        rdat = wb_dat_r;                                 // Valid while ack is high
        @(posedge clk24);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk24);
        if (wb_ack) begin
            $display("ERROR %0t: ack lasted two cycles at address %h", $time, adr);
            bus_errs++;
        end
    endtask

    // Bus write plus the same decode on the local copies
    task automatic write_reg(input logic [6:0] adr, input logic [7:0] dat);
        logic [7:0] rd_dummy;
        bus_access(1'b1, adr, dat, rd_dummy);
        if (adr == 7'h00) begin
            if (dat[0] && !tb_enable) begin
                rd_ptr  = pix_q.size();                  // New line from column 0
                pix_num = 0;
            end
            tb_enable = dat[0];
        end else if (adr >= 7'h10 && adr <= 7'h1f) begin
            pal_m[adr[3:0]] = dat;
        end else if (adr >= 7'h40 && adr <= 7'h5f) begin
            plane_m[adr[4:3]][adr[2:0]] = dat;
        end                                              // Other addresses dropped
    endtask

    task automatic check_pixel(input logic from_file, input logic [7:0] file_color);
        int         t;
        logic [7:0] got;
        logic [7:0] exp;
        t = 0;
        if (aborted) return;
        while (rd_ptr >= pix_q.size() && t < PIX_TIMEOUT) begin
            t++;
            @(negedge clk24);
        end
        if (rd_ptr >= pix_q.size()) begin
            $display("No pixel strobe arrived within %0d cycles", PIX_TIMEOUT);
            aborted = 1'b1;
            return;
        end
        got = pix_q[rd_ptr];
        rd_ptr++;
        exp = model_color(pix_num);
        if (got !== exp) begin
            $display("ERROR %0t: pixel %0d colour %h, model gives %h", $time, pix_num, got, exp);
            data_errs++;
        end
        if (from_file && got !== file_color) begin
            $display("ERROR %0t: pixel %0d colour %h, file gives %h", $time, pix_num, got,
                     file_color);
            data_errs++;
        end
        pix_num++;
    endtask

    // Rising edges against modelled accumulator wraps
    task automatic check_subcarrier();
        logic [31:0] acc;
        logic [32:0] sum;
        logic        prev;
        int          rises;
        int          wraps;
        acc   = 32'h0;
        rises = 0;
        wraps = 0;
        @(negedge clk24);
        prev = subcarrier;
        for (int i = 0; i < 4096; i++) begin
            @(negedge clk24);
            if (subcarrier && !prev) rises++;
            prev = subcarrier;
            sum  = {1'b0, acc} + {1'b0, SUB_DELTA};
            acc  = sum[31:0];
            if (sum[32]) wraps++;
        end
        if (rises - wraps > 1 || wraps - rises > 1) begin
            $display("ERROR %0t: %0d subcarrier edges, %0d wraps expected", $time, rises, wraps);
            data_errs++;
        end
    endtask

    // ------------------------------
    // Pixel monitor
    // ------------------------------
    initial begin : pixel_monitor
        int gap;
        int dis_cycles;
        bit have_last;
        bit prev_en;
        gap        = 0;
        dis_cycles = 1000;                               // Strict until the first enable
        have_last  = 1'b0;
        prev_en    = 1'b0;
        forever begin
            @(negedge clk24);
            gap++;
            if (prev_en && !tb_enable) dis_cycles = 0;   // Grace for the strobe in flight
            if (!prev_en && tb_enable) have_last = 1'b0;
            if (pixel_valid) begin
                if (tb_enable) begin
                    if (have_last && gap != 4) begin
                        $display("ERROR %0t: pixel strobes %0d cycles apart", $time, gap);
                        timing_errs++;
                    end
                    pix_q.push_back(pixel_color);
                end else if (dis_cycles >= 2) begin
                    $display("ERROR %0t: pixel strobe while the line is disabled", $time);
                    timing_errs++;
                end
                have_last = 1'b1;
                gap       = 0;
            end
            if (!tb_enable && dis_cycles < 1000) dis_cycles++;
            prev_en = tb_enable;
        end
    end

    // ------------------------------
    // Stimulus from the input file
    // ------------------------------
    initial begin : stimulus
        int          fd;
        int          code;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        logic [7:0]  rd;
        logic [7:0]  val;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 7'h00;
        wb_dat_w = 8'h00;
        lfsr     = 32'h66ae_d215;
        for (int p = 0; p < 4; p++) begin
            for (int c = 0; c < 8; c++) plane_m[p][c] = 8'h00;
        end
        repeat (4) @(posedge clk24);
        rst_n <= 1'b1;
        @(negedge clk24);
        if (wb_ack !== 1'b0 || pixel_valid !== 1'b0 || pixel_color !== 8'h00) begin
            $display("ERROR %0t: outputs not idle after reset", $time);
            data_errs++;
        end
        for (int e = 0; e < 16; e++) begin               // Random palette that the file may override
            val = 8'h00;
            for (int b = 0; b < 8; b++) begin
                lfsr = lfsr_next(lfsr);
                val  = {val[6:0], lfsr[0]};
            end
            write_reg(7'(16 + e), val);
        end
        fd = $fopen("tb/video_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/video_input.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 3 || line[0] == "#") continue;
            op   = line[0];
            a    = 32'h0;
            d    = 32'h0;
            code = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, d);
            case (op)
                "W": write_reg(a[6:0], d[7:0]);
                "R": begin
                    bus_access(1'b0, a[6:0], 8'h00, rd);
                    if (!aborted && rd !== d[7:0]) begin
                        $display("ERROR %0t: read %h gave %h, expected %h", $time, a[6:0], rd,
                                 d[7:0]);
                        data_errs++;
                    end
                end
                "X": begin
                    n = int'(a);
                    for (int i = 0; i < n && !aborted; i++) check_pixel(1'b0, 8'h00);
                end
                "P": check_pixel(1'b1, a[7:0]);
                default: begin
                    $display("Unknown opcode in tb/video_input.txt: %s", line);
                    aborted = 1'b1;
                end
            endcase
        end
        if (fd != 0) $fclose(fd);
        if (!aborted) check_subcarrier();
        $display("Errors: bus %0d, data %0d, timing %0d", bus_errs, data_errs, timing_errs);
        if (bus_errs == 0 && data_errs == 0 && timing_errs == 0 && !aborted) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/video_assert.sv
`timescale 1ns/10ps

module video_assert (
    input logic clk24,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic ce12,
    input logic ce6,
    input logic ce6x,
    input logic ce3,
    input logic ce1m5,
    input logic video_slice,
    input logic pipe_ab
);

    // ------------------------------
    // Enable patterns
    // ------------------------------
    a_ce12_ce6: assert property (@(posedge clk24) disable iff (!rst_n) ce6 |-> ce12)
        else $error("ce12 low during ce6");
    a_ce12_half: assert property (@(posedge clk24) disable iff (!rst_n) ce12 |=> !ce12)
        else $error("ce12 high for two cycles");
    a_ce6x_ce6: assert property (@(posedge clk24) disable iff (!rst_n) ce6x |=> ce6)
        else $error("ce6x not followed by ce6");
    a_ce3_pulse: assert property (@(posedge clk24) disable iff (!rst_n) ce3 |=> !ce3)
        else $error("ce3 longer than one cycle");
    a_ce1m5_pulse: assert property (@(posedge clk24) disable iff (!rst_n) ce1m5 |=> !ce1m5)
        else $error("ce1m5 longer than one cycle");
    a_slice_rise: assert property (@(posedge clk24) disable iff (!rst_n)
        $rose(video_slice) |-> ##4 $fell(video_slice))   // 4 high
        else $error("video_slice high period not 4 cycles");
    a_slice_fall: assert property (@(posedge clk24) disable iff (!rst_n)
        $fell(video_slice) |-> ##4 $rose(video_slice))   // 4 low
        else $error("video_slice low period not 4 cycles");

    // Top counter bit, 32 cycles per level
    a_pipe_rise: assert property (@(posedge clk24) disable iff (!rst_n)
        $rose(pipe_ab) |-> ##32 $fell(pipe_ab))
        else $error("pipe_ab high period not 32 cycles");
    a_pipe_fall: assert property (@(posedge clk24) disable iff (!rst_n)
        $fell(pipe_ab) |-> ##32 $rose(pipe_ab))
        else $error("pipe_ab low period not 32 cycles");

    // Wishbone ack shape
    a_ack_single: assert property (@(posedge clk24) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles");
    a_ack_after_stb: assert property (@(posedge clk24) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a preceding strobe");

endmodule

// File: source/video_top.sv
`timescale 1ns/10ps

module video_top (
    input  logic                              clk24,
    input  logic                              rst_n,
    // Wishbone classic slave
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [video_pkg::WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [video_pkg::WB_DAT_WIDTH-1:0] wb_dat_w,
    output logic [video_pkg::WB_DAT_WIDTH-1:0] wb_dat_r,
    output logic                              wb_ack,
    // Video out
    output logic [video_pkg::COLOR_WIDTH-1:0]  pixel_color,
    output logic                              pixel_valid,
    output logic                              subcarrier
);

    logic [video_pkg::PLANES-1:0] index;
    logic                         index_valid;

    ce_if    ce_bus ();
    fetch_if fetch_bus ();
    pal_if   pal_bus ();

    clock_enables clock_enables_i (
        .clk24      (clk24),
        .rst_n      (rst_n),
        .ce         (ce_bus.gen),
        .subcarrier (subcarrier)
    );

    wb_regs wb_regs_i (
        .clk24    (clk24),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .fetch    (fetch_bus.host),
        .pal      (pal_bus.tbl)
    );

    pixel_shifter pixel_shifter_i (
        .clk24       (clk24),
        .rst_n       (rst_n),
        .ce          (ce_bus.user),
        .fetch       (fetch_bus.shifter),
        .index       (index),
        .index_valid (index_valid)
    );

    palette_out palette_out_i (
        .clk24       (clk24),
        .rst_n       (rst_n),
        .index       (index),
        .index_valid (index_valid),
        .pal         (pal_bus.lookup),
        .pixel_color (pixel_color),
        .pixel_valid (pixel_valid)
    );

endmodule

// File: source/palette_out.sv
`timescale 1ns/10ps

module palette_out (
    input  logic                             clk24,
    input  logic                             rst_n,
    input  logic [video_pkg::PLANES-1:0]      index,
    input  logic                             index_valid,
    pal_if.lookup                            pal,
    output logic [video_pkg::COLOR_WIDTH-1:0] pixel_color,
    output logic                             pixel_valid
);

    // Index is registered in the shifter, stable during the strobe
    assign pal.index = index;

    // ------------------------------
    // Registered colour output
    // ------------------------------
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            pixel_color <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= index_valid;                  // One cycle behind the index
            if (index_valid) begin
                pixel_color <= pal.color;                // Held between strobes
            end
        end
    end

endmodule

// File: source/pixel_shifter.sv
`timescale 1ns/10ps

module pixel_shifter (
    input  logic                        clk24,
    input  logic                        rst_n,
    ce_if.user                          ce,
    fetch_if.shifter                    fetch,
    output logic [video_pkg::PLANES-1:0] index,
    output logic                        index_valid
);

    logic                                    running;
    logic [$clog2(video_pkg::COLUMNS)-1:0]   col;
    logic [$clog2(video_pkg::WB_DAT_WIDTH)-1:0] pos;    // Bit position within the byte
    logic [video_pkg::PLANES-1:0][video_pkg::WB_DAT_WIDTH-1:0] sr;
    logic [video_pkg::PLANES-1:0]            msbs;
    logic                                    load;
    logic                                    emit;

    assign fetch.col = col;

    // Line starts inside the video slice; later loads fall in the same phase
    assign load = ce.ce6x && (pos == '0) && (running || ce.video_slice);
    assign emit = running && ce.ce6;

    // Plane 3 is index bit 3
    always_comb begin
        for (int p = 0; p < video_pkg::PLANES; p++) begin
            msbs[p] = sr[p][video_pkg::WB_DAT_WIDTH-1];
        end
    end

    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            running     <= 1'b0;
            col         <= '0;
            pos         <= '0;
            sr          <= '0;
            index       <= '0;
            index_valid <= 1'b0;
        end else if (!fetch.enable) begin
            running     <= 1'b0;                         // Idle, next line from column 0
            col         <= '0;
            pos         <= '0;
            sr          <= '0;
            index       <= '0;
            index_valid <= 1'b0;
        end else begin
            index_valid <= 1'b0;
            if (load) begin
                running <= 1'b1;
                sr      <= fetch.plane_bytes;            // Column bytes of all planes
            end
            if (emit) begin
                index       <= msbs;
                index_valid <= 1'b1;
                for (int p = 0; p < video_pkg::PLANES; p++) begin
                    sr[p] <= {sr[p][video_pkg::WB_DAT_WIDTH-2:0], 1'b0}; // MSB first
                end
                pos <= pos + 1'b1;
                if (&pos) col <= col + 1'b1;             // Wraps after the last column
            end
        end
    end

endmodule

// File: source/wb_regs.sv
`timescale 1ns/10ps

module wb_regs (
    input  logic                              clk24,
    input  logic                              rst_n,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [video_pkg::WB_ADR_WIDTH-1:0] wb_adr,
    input  logic [video_pkg::WB_DAT_WIDTH-1:0] wb_dat_w,
    output logic [video_pkg::WB_DAT_WIDTH-1:0] wb_dat_r,
    output logic                              wb_ack,
    fetch_if.host                             fetch,
    pal_if.tbl                                pal
);

    video_pkg::wb_state_e  state;
    video_pkg::wb_region_e region;

    logic [video_pkg::WB_DAT_WIDTH-1:0] ctrl;
    logic [video_pkg::COLOR_WIDTH-1:0]  palette [video_pkg::PAL_ENTRIES];
    logic [video_pkg::WB_DAT_WIDTH-1:0] planes  [video_pkg::PLANES][video_pkg::COLUMNS];

    logic [$clog2(video_pkg::PAL_ENTRIES)-1:0] pal_sel;
    logic [$clog2(video_pkg::PLANES)-1:0]      plane_sel;
    logic [$clog2(video_pkg::COLUMNS)-1:0]     col_sel;
    logic                                      start;

    assign start     = wb_cyc & wb_stb & (state == video_pkg::WB_IDLE);
    assign pal_sel   = wb_adr[3:0];
    assign plane_sel = wb_adr[4:3];
    assign col_sel   = wb_adr[2:0];
    assign wb_ack    = (state == video_pkg::WB_ACK);     // Exactly one cycle per access

    // Region from the upper address bits
    always_comb begin
        if (wb_adr == '0)
            region = video_pkg::REGION_CTRL;
        else if (wb_adr[6:4] == 3'b001)
            region = video_pkg::REGION_PALETTE;
        else if (wb_adr[6:5] == 2'b10)
            region = video_pkg::REGION_PLANE;
        else
            region = video_pkg::REGION_NONE;
    end

    // ------------------------------
    // Bus FSM and register file
    // ------------------------------
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= video_pkg::WB_IDLE;
            wb_dat_r <= '0;
            ctrl     <= '0;
            for (int e = 0; e < video_pkg::PAL_ENTRIES; e++) palette[e] <= '0;
            for (int p = 0; p < video_pkg::PLANES; p++) begin
                for (int c = 0; c < video_pkg::COLUMNS; c++) planes[p][c] <= '0;
            end
        end else begin
            case (state)
                video_pkg::WB_IDLE: begin
                    if (start) begin
                        state    <= video_pkg::WB_ACK;   // Write lands as ack rises
                        wb_dat_r <= '0;                  // Default covers REGION_NONE
                        case (region)
                            video_pkg::REGION_CTRL:
                                if (wb_we) ctrl <= wb_dat_w;
                                else       wb_dat_r <= ctrl;
                            video_pkg::REGION_PALETTE:
                                if (wb_we) palette[pal_sel] <= wb_dat_w;
                                else       wb_dat_r <= palette[pal_sel];
                            video_pkg::REGION_PLANE:
                                if (wb_we) planes[plane_sel][col_sel] <= wb_dat_w;
                                else       wb_dat_r <= planes[plane_sel][col_sel];
                            default: ;                   // Dropped
                        endcase
                    end
                end
                video_pkg::WB_ACK: state <= video_pkg::WB_IDLE; // No back-to-back ack
                default:           state <= video_pkg::WB_IDLE;
            endcase
        end
    end

    // Shifter and palette side, combinational reads
    assign fetch.enable = ctrl[0];
    assign pal.color    = palette[pal.index];

    always_comb begin
        for (int p = 0; p < video_pkg::PLANES; p++) begin
            fetch.plane_bytes[p] = planes[p][fetch.col];
        end
    end

endmodule

// File: source/clock_enables.sv
`timescale 1ns/10ps

module clock_enables (
    input  logic clk24,
    input  logic rst_n,
    ce_if.gen    ce,
    output logic subcarrier
);

    logic [video_pkg::CTR_WIDTH-1:0]   ctr;
    logic [video_pkg::INIT_WIDTH-1:0]  init_ctr;
    logic [video_pkg::PHACC_WIDTH-1:0] phase;

    // ------------------------------
    // Startup delay and enable decode
    // ------------------------------
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            init_ctr       <= '0;
            ctr            <= '0;
            ce.ce12        <= 1'b0;
            ce.ce6         <= 1'b0;
            ce.ce6x        <= 1'b0;
            ce.ce3         <= 1'b0;
            ce.ce1m5       <= 1'b0;
            ce.video_slice <= 1'b0;
            ce.pipe_ab     <= 1'b0;
        end else if (init_ctr != video_pkg::INIT_CYCLES[video_pkg::INIT_WIDTH-1:0]) begin
            init_ctr <= init_ctr + 1'b1;                 // Counter held, enables stay low
        end else begin
            ce.pipe_ab     <= ctr[5];                    // Half rate of the 32-cycle loop
            ce.ce12        <= ctr[0];
            ce.ce6         <= ctr[1] & ctr[0];           // xx11
            ce.ce6x        <= ctr[1] & ~ctr[0];          // xx10, one ahead of ce6
            ce.ce3         <= ctr[2] & ctr[1] & ~ctr[0]; // Once in 8
            ce.ce1m5       <= ~ctr[3] & ctr[2] & ctr[1] & ~ctr[0]; // Once in 16
            ce.video_slice <= ~ctr[2];
            ctr            <= ctr + 1'b1;
        end
    end

    // ------------------------------
    // PAL subcarrier
    // ------------------------------
    // Runs from reset release, independent of the startup delay
    always_ff @(posedge clk24 or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + video_pkg::PHACC_DELTA;
        end
    end

    assign subcarrier = phase[video_pkg::PHACC_WIDTH-1]; // Square wave from the MSB

endmodule

// File: source/video_ifs.sv
`timescale 1ns/10ps

// Enables from the counter, all single clk24 cycles unless noted
interface ce_if;
    logic ce12;                 // Every other cycle
    logic ce6;                  // Pixel push
    logic ce6x;                 // Pre-pixel push, one cycle before ce6
    logic ce3;
    logic ce1m5;
    logic video_slice;          // Level, 4 of 8 cycles
    logic pipe_ab;              // Level, top counter bit

    modport gen (output ce12, ce6, ce6x, ce3, ce1m5, video_slice, pipe_ab);
    modport user (input ce6, ce6x, video_slice);
endinterface

// Line buffer column fetch
interface fetch_if;
    logic enable;               // Control bit 0
    logic [video_pkg::PLANES-1:0][video_pkg::WB_DAT_WIDTH-1:0] plane_bytes;
    logic [$clog2(video_pkg::COLUMNS)-1:0] col;

    modport host (output enable, plane_bytes, input col);
    modport shifter (input enable, plane_bytes, output col);
endinterface

// Palette table lookup, combinational
interface pal_if;
    logic [$clog2(video_pkg::PAL_ENTRIES)-1:0] index;
    logic [video_pkg::COLOR_WIDTH-1:0] color;

    modport tbl (input index, output color);
    modport lookup (output index, input color);
endinterface

// File: source/video_pkg.sv
package video_pkg;

    // ------------------------------
    // Clock enable generator
    // ------------------------------
    localparam int CTR_WIDTH   = 6;                      // Free running enable counter
    localparam int INIT_CYCLES = 3;                      // Counter hold after reset
    localparam int INIT_WIDTH  = $clog2(INIT_CYCLES + 1);

    // 4.43361875 MHz / 24 MHz * 2^32, rounded
    localparam int PHACC_WIDTH = 32;
    localparam logic [PHACC_WIDTH-1:0] PHACC_DELTA = 32'd793426981;

    // ------------------------------
    // Video line and palette
    // ------------------------------
    localparam int PLANES      = 4;                      // One bit of colour index each
    localparam int COLUMNS     = 8;                      // Bytes per plane in one line
    localparam int PAL_ENTRIES = 16;
    localparam int COLOR_WIDTH = 8;

    // ------------------------------
    // Wishbone slave
    // ------------------------------
    localparam int WB_ADR_WIDTH = 7;
    localparam int WB_DAT_WIDTH = 8;

    typedef enum logic [1:0] {
        REGION_CTRL    = 2'd0,                           // 0x00
        REGION_PALETTE = 2'd1,                           // 0x10..0x1f
        REGION_PLANE   = 2'd2,                           // 0x40..0x5f, plane in [4:3]
        REGION_NONE    = 2'd3                            // Acked, reads as zero
    } wb_region_e;

    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

endpackage
